// File: include/mem_sys_macros.svh
`ifndef MEM_SYS_MACROS_SVH
`define MEM_SYS_MACROS_SVH

// bus and line geometry
`define MEM_ADDR_W   32
`define MEM_WORD_W   32
`define MEM_LINE_W   256
`define MEM_BURST_W  64
`define MEM_BURSTS   4

// direct-mapped cache shape
`define MEM_SETS_W   3
`define MEM_OFFSET_W 5

`define CSR_ADDR_W   3

`endif

// File: design/mem_types_pkg.sv
`default_nettype none
`include "mem_sys_macros.svh"

package mem_types_pkg;

    typedef logic [`MEM_WORD_W-1:0]   word_t;
    typedef logic [`MEM_LINE_W-1:0]   line_t;
    typedef logic [`MEM_BURST_W-1:0]  burst_t;

    // byte enables
    typedef logic [`MEM_WORD_W/8-1:0] wmask_t;
    typedef logic [`MEM_LINE_W/8-1:0] line_mask_t;

    typedef logic [`MEM_ADDR_W-`MEM_SETS_W-`MEM_OFFSET_W-1:0] tag_t;
    typedef logic [`MEM_SETS_W-1:0]   set_t;

    typedef logic [31:0]              count_t;  // event counter

endpackage

`default_nettype wire

// File: design/mem_fsm_pkg.sv
`default_nettype none

package mem_fsm_pkg;

    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_WB,    // dirty victim going out
        CACHE_FILL
    } cache_state_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_ICACHE, ARB_DCACHE} arb_state_t;

    typedef enum logic [1:0] {ADAPT_IDLE, ADAPT_READ, ADAPT_WRITE, ADAPT_DONE} adapt_state_t;

endpackage

`default_nettype wire

// File: design/cache.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module cache (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire  mem_types_pkg::word_t  address_i,
    input  wire                         read_i,
    input  wire                         write_i,
    input  wire  mem_types_pkg::wmask_t wmask_i,
    input  wire  mem_types_pkg::word_t  wdata_i,
    output mem_types_pkg::word_t        rdata_o,
    output logic                        resp_o,
    output mem_types_pkg::word_t        pmem_address_o,
    output logic                        pmem_read_o,
    output logic                        pmem_write_o,
    output mem_types_pkg::line_t        pmem_wdata_o,
    input  wire  mem_types_pkg::line_t  pmem_rdata_i,
    input  wire                         pmem_resp_i,
    output logic                        hit_o,
    output logic                        miss_o
);

    mem_fsm_pkg::cache_state_t state_q;

    // per-set storage
    mem_types_pkg::line_t      data_q [2**`MEM_SETS_W];
    mem_types_pkg::tag_t       tag_q  [2**`MEM_SETS_W];
    logic [2**`MEM_SETS_W-1:0] valid_q;
    logic [2**`MEM_SETS_W-1:0] dirty_q;

    mem_types_pkg::set_t       set;
    mem_types_pkg::tag_t       tag;
    logic [`MEM_OFFSET_W-3:0]  word_idx;
    logic                      lookup;
    logic                      hit;
    logic                      fill_done;
    logic                      line_we;
    mem_types_pkg::line_mask_t line_mask;
    mem_types_pkg::line_t      src_line;
    mem_types_pkg::line_t      new_line;

    assign set      = address_i[`MEM_OFFSET_W +: `MEM_SETS_W];
    assign tag      = address_i[`MEM_ADDR_W-1:`MEM_OFFSET_W+`MEM_SETS_W];
    assign word_idx = address_i[`MEM_OFFSET_W-1:2];

    // resp_o high means the held request was already answered
    assign lookup    = (state_q == mem_fsm_pkg::CACHE_IDLE) & (read_i | write_i) & ~resp_o;
    assign hit       = valid_q[set] & (tag_q[set] == tag);
    assign fill_done = (state_q == mem_fsm_pkg::CACHE_FILL) & pmem_resp_i;
    assign line_we   = fill_done | (lookup & hit & write_i);

    // byte lanes of the addressed word within the line
    assign line_mask = write_i ? (mem_types_pkg::line_mask_t'(wmask_i) << {word_idx, 2'b00}) : '0;
    assign src_line  = (state_q == mem_fsm_pkg::CACHE_FILL) ? pmem_rdata_i : data_q[set];

    always_comb begin
        for (int b = 0; b < `MEM_LINE_W/8; b++) begin
            new_line[8*b +: 8] = line_mask[b] ? wdata_i[8*(b % (`MEM_WORD_W/8)) +: 8]
                                              : src_line[8*b +: 8];
        end
    end

    assign pmem_read_o    = (state_q == mem_fsm_pkg::CACHE_FILL);
    assign pmem_write_o   = (state_q == mem_fsm_pkg::CACHE_WB);
    assign pmem_wdata_o   = data_q[set];
    assign pmem_address_o = pmem_write_o ? {tag_q[set], set, `MEM_OFFSET_W'(0)}
                                         : {tag, set, `MEM_OFFSET_W'(0)};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_fsm_pkg::CACHE_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            resp_o  <= 1'b0;
            hit_o   <= 1'b0;
            miss_o  <= 1'b0;
        end else begin
            resp_o <= fill_done | (lookup & hit);
            hit_o  <= lookup & hit;
            miss_o <= lookup & ~hit;   // once per request
            case (state_q)
                mem_fsm_pkg::CACHE_IDLE: begin
                    if (lookup & hit & write_i) begin
                        dirty_q[set] <= 1'b1;
                    end else if (lookup & ~hit) begin
                        state_q <= (valid_q[set] & dirty_q[set]) ? mem_fsm_pkg::CACHE_WB
                                                                 : mem_fsm_pkg::CACHE_FILL;
                    end
                end
                mem_fsm_pkg::CACHE_WB: begin
                    if (pmem_resp_i) state_q <= mem_fsm_pkg::CACHE_FILL;
                end
                mem_fsm_pkg::CACHE_FILL: begin
                    if (pmem_resp_i) begin   // answer straight from the fill
                        state_q      <= mem_fsm_pkg::CACHE_IDLE;
                        valid_q[set] <= 1'b1;
                        dirty_q[set] <= write_i;
                    end
                end
                default: state_q <= mem_fsm_pkg::CACHE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) data_q[set] <= new_line;
        if (fill_done) tag_q[set] <= tag;
        rdata_o <= new_line[{word_idx, 5'b00000} +: `MEM_WORD_W];
    end

    // line port answers only a request this cache is holding
    a_pmem_resp_when_asked: assert property (@(posedge clk) disable iff (reset_i)
        pmem_resp_i |-> (pmem_read_o || pmem_write_o));

endmodule

`default_nettype wire

// File: design/cache_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cache_arbiter (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        prio_icache_i,
    input  wire  mem_types_pkg::word_t icache_address_i,
    input  wire                        icache_read_i,
    output mem_types_pkg::line_t       icache_rdata_o,
    output logic                       icache_resp_o,
    input  wire  mem_types_pkg::word_t dcache_address_i,
    input  wire                        dcache_read_i,
    input  wire                        dcache_write_i,
    input  wire  mem_types_pkg::line_t dcache_wdata_i,
    output mem_types_pkg::line_t       dcache_rdata_o,
    output logic                       dcache_resp_o,
    output mem_types_pkg::word_t       mem_address_o,
    output logic                       mem_read_o,
    output logic                       mem_write_o,
    output mem_types_pkg::line_t       mem_wdata_o,
    input  wire  mem_types_pkg::line_t mem_rdata_i,
    input  wire                        mem_resp_i
);

    mem_fsm_pkg::arb_state_t state_q;
    logic i_granted;
    logic d_granted;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_fsm_pkg::ARB_IDLE;
        end else begin
            case (state_q)
                mem_fsm_pkg::ARB_IDLE: begin
                    // dcache first unless the priority bit favours the icache
                    if ((dcache_read_i | dcache_write_i) & ~(icache_read_i & prio_icache_i))
                        state_q <= mem_fsm_pkg::ARB_DCACHE;
                    else if (icache_read_i)
                        state_q <= mem_fsm_pkg::ARB_ICACHE;
                end
                mem_fsm_pkg::ARB_ICACHE, mem_fsm_pkg::ARB_DCACHE: begin
                    if (mem_resp_i) state_q <= mem_fsm_pkg::ARB_IDLE;  // one idle cycle
                end
                default: state_q <= mem_fsm_pkg::ARB_IDLE;
            endcase
        end
    end

    assign i_granted = (state_q == mem_fsm_pkg::ARB_ICACHE);
    assign d_granted = (state_q == mem_fsm_pkg::ARB_DCACHE);

    assign mem_address_o = i_granted ? icache_address_i : dcache_address_i;
    assign mem_read_o    = (i_granted & icache_read_i) | (d_granted & dcache_read_i);
    assign mem_write_o   = d_granted & dcache_write_i;  // icache never writes
    assign mem_wdata_o   = dcache_wdata_i;

    assign icache_resp_o  = i_granted & mem_resp_i;
    assign dcache_resp_o  = d_granted & mem_resp_i;
    assign icache_rdata_o = i_granted ? mem_rdata_i : '0;
    assign dcache_rdata_o = d_granted ? mem_rdata_i : '0;

    // adaptor answers only a request that is being forwarded
    a_resp_when_forwarded: assert property (@(posedge clk) disable iff (reset_i)
        mem_resp_i |-> (mem_read_o || mem_write_o));

endmodule

`default_nettype wire

// File: design/cacheline_adaptor.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module cacheline_adaptor (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire  mem_types_pkg::line_t  line_i,
    output mem_types_pkg::line_t        line_o,
    input  wire  mem_types_pkg::word_t  address_i,
    input  wire                         read_i,
    input  wire                         write_i,
    output logic                        resp_o,
    input  wire  mem_types_pkg::burst_t burst_i,
    output mem_types_pkg::burst_t       burst_o,
    output mem_types_pkg::word_t        address_o,
    output logic                        read_o,
    output logic                        write_o,
    input  wire                         resp_i
);

    mem_fsm_pkg::adapt_state_t         state_q;
    logic [$clog2(`MEM_BURSTS)-1:0]    beat_q;
    mem_types_pkg::line_t              line_q;   // write source or read assembly
    mem_types_pkg::word_t              addr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= mem_fsm_pkg::ADAPT_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                mem_fsm_pkg::ADAPT_IDLE: begin
                    beat_q <= '0;
                    if (read_i)
                        state_q <= mem_fsm_pkg::ADAPT_READ;
                    else if (write_i)
                        state_q <= mem_fsm_pkg::ADAPT_WRITE;
                end
                mem_fsm_pkg::ADAPT_READ, mem_fsm_pkg::ADAPT_WRITE: begin
                    if (resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == `MEM_BURSTS-1) state_q <= mem_fsm_pkg::ADAPT_DONE;
                    end
                end
                default: state_q <= mem_fsm_pkg::ADAPT_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mem_fsm_pkg::ADAPT_IDLE) begin
            addr_q <= address_i;
            line_q <= line_i;
        end else if ((state_q == mem_fsm_pkg::ADAPT_READ) && resp_i) begin
            line_q[beat_q*`MEM_BURST_W +: `MEM_BURST_W] <= burst_i;  // lowest burst first
        end
    end

    assign read_o    = (state_q == mem_fsm_pkg::ADAPT_READ);
    assign write_o   = (state_q == mem_fsm_pkg::ADAPT_WRITE);
    assign address_o = addr_q;
    assign burst_o   = line_q[beat_q*`MEM_BURST_W +: `MEM_BURST_W];
    assign resp_o    = (state_q == mem_fsm_pkg::ADAPT_DONE);
    assign line_o    = line_q;

    // memory must not answer a request that was never made
    a_no_stray_beat: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == mem_fsm_pkg::ADAPT_IDLE) |-> !resp_i);

endmodule

`default_nettype wire

// File: design/mem_sys_csr.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module mem_sys_csr (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        i_hit_i,
    input  wire                        i_miss_i,
    input  wire                        d_hit_i,
    input  wire                        d_miss_i,
    input  wire                        csr_wr_i,
    input  wire  mem_types_pkg::word_t csr_wdata_i,
    input  wire  [`CSR_ADDR_W-1:0]     csr_addr_i,
    output mem_types_pkg::word_t       csr_rdata_o,
    output logic                       prio_icache_o
);

    mem_types_pkg::count_t i_hits_q;
    mem_types_pkg::count_t i_misses_q;
    mem_types_pkg::count_t d_hits_q;
    mem_types_pkg::count_t d_misses_q;
    logic                  prio_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            i_hits_q   <= '0;
            i_misses_q <= '0;
            d_hits_q   <= '0;
            d_misses_q <= '0;
            prio_q     <= 1'b0;
        end else begin
            if (i_hit_i) i_hits_q <= i_hits_q + 1'b1;
            if (i_miss_i) i_misses_q <= i_misses_q + 1'b1;
            if (d_hit_i) d_hits_q <= d_hits_q + 1'b1;
            if (d_miss_i) d_misses_q <= d_misses_q + 1'b1;
            if (csr_wr_i) prio_q <= csr_wdata_i[0];  // only writable bit
        end
    end

    always_comb begin
        case (csr_addr_i)
            3'd0:    csr_rdata_o = i_hits_q;
            3'd1:    csr_rdata_o = i_misses_q;
            3'd2:    csr_rdata_o = d_hits_q;
            3'd3:    csr_rdata_o = d_misses_q;
            3'd4:    csr_rdata_o = mem_types_pkg::word_t'(prio_q);
            default: csr_rdata_o = '0;
        endcase
    end

    assign prio_icache_o = prio_q;

endmodule

`default_nettype wire

// File: design/mem_sys.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module mem_sys (
    input  wire                         clk,
    input  wire                         reset_i,
    // fetch side
    input  wire  mem_types_pkg::word_t  imem_address_i,
    input  wire                         imem_read_i,
    output mem_types_pkg::word_t        imem_rdata_o,
    output logic                        imem_resp_o,
    // load and store side
    input  wire  mem_types_pkg::word_t  dmem_address_i,
    input  wire                         dmem_read_i,
    input  wire                         dmem_write_i,
    input  wire  mem_types_pkg::wmask_t dmem_wmask_i,
    input  wire  mem_types_pkg::word_t  dmem_wdata_i,
    output mem_types_pkg::word_t        dmem_rdata_o,
    output logic                        dmem_resp_o,
    // burst memory
    output mem_types_pkg::word_t        bmem_address_o,
    output logic                        bmem_read_o,
    output logic                        bmem_write_o,
    input  wire  mem_types_pkg::burst_t bmem_rdata_i,
    output mem_types_pkg::burst_t       bmem_wdata_o,
    input  wire                         bmem_resp_i,
    // register port
    input  wire                         csr_wr_i,
    input  wire  mem_types_pkg::word_t  csr_wdata_i,
    input  wire  [`CSR_ADDR_W-1:0]      csr_addr_i,
    output mem_types_pkg::word_t        csr_rdata_o
);

    logic i_hit, i_miss, d_hit, d_miss;
    logic prio_icache;

    // cache to arbiter
    mem_types_pkg::word_t ic_address, dc_address;
    mem_types_pkg::line_t ic_rdata, dc_rdata, dc_wdata;
    logic                 ic_read, ic_resp;
    logic                 dc_read, dc_write, dc_resp;

    // arbiter to adaptor
    mem_types_pkg::word_t line_address;
    mem_types_pkg::line_t line_wdata, line_rdata;
    logic                 line_read, line_write, line_resp;

    cache icache0 (
        .clk(clk), .reset_i(reset_i),
        .address_i(imem_address_i), .read_i(imem_read_i),
        .write_i(1'b0), .wmask_i('0), .wdata_i('0),   // read-only use
        .rdata_o(imem_rdata_o), .resp_o(imem_resp_o),
        .pmem_address_o(ic_address), .pmem_read_o(ic_read),
        .pmem_write_o(), .pmem_wdata_o(),
        .pmem_rdata_i(ic_rdata), .pmem_resp_i(ic_resp),
        .hit_o(i_hit), .miss_o(i_miss)
    );

    cache dcache0 (
        .clk(clk), .reset_i(reset_i),
        .address_i(dmem_address_i), .read_i(dmem_read_i),
        .write_i(dmem_write_i), .wmask_i(dmem_wmask_i), .wdata_i(dmem_wdata_i),
        .rdata_o(dmem_rdata_o), .resp_o(dmem_resp_o),
        .pmem_address_o(dc_address), .pmem_read_o(dc_read),
        .pmem_write_o(dc_write), .pmem_wdata_o(dc_wdata),
        .pmem_rdata_i(dc_rdata), .pmem_resp_i(dc_resp),
        .hit_o(d_hit), .miss_o(d_miss)
    );

    cache_arbiter cache_arbiter (
        .clk(clk), .reset_i(reset_i), .prio_icache_i(prio_icache),
        .icache_address_i(ic_address), .icache_read_i(ic_read),
        .icache_rdata_o(ic_rdata), .icache_resp_o(ic_resp),
        .dcache_address_i(dc_address), .dcache_read_i(dc_read),
        .dcache_write_i(dc_write), .dcache_wdata_i(dc_wdata),
        .dcache_rdata_o(dc_rdata), .dcache_resp_o(dc_resp),
        .mem_address_o(line_address), .mem_read_o(line_read),
        .mem_write_o(line_write), .mem_wdata_o(line_wdata),
        .mem_rdata_i(line_rdata), .mem_resp_i(line_resp)
    );

    cacheline_adaptor cacheline_adaptor (
        .clk(clk), .reset_i(reset_i),
        .line_i(line_wdata), .line_o(line_rdata), .address_i(line_address),
        .read_i(line_read), .write_i(line_write), .resp_o(line_resp),
        .burst_i(bmem_rdata_i), .burst_o(bmem_wdata_o), .address_o(bmem_address_o),
        .read_o(bmem_read_o), .write_o(bmem_write_o), .resp_i(bmem_resp_i)
    );

    mem_sys_csr mem_sys_csr (
        .clk(clk), .reset_i(reset_i),
        .i_hit_i(i_hit), .i_miss_i(i_miss), .d_hit_i(d_hit), .d_miss_i(d_miss),
        .csr_wr_i(csr_wr_i), .csr_wdata_i(csr_wdata_i), .csr_addr_i(csr_addr_i),
        .csr_rdata_o(csr_rdata_o), .prio_icache_o(prio_icache)
    );

endmodule

`default_nettype wire

// File: verif/burst_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module burst_mem_model (
    input  wire         clk,
    input  wire         reset_i,
    input  wire  [31:0] address_i,
    input  wire         read_i,
    input  wire         write_i,
    input  wire  [63:0] wdata_i,
    output logic [63:0] rdata_o,
    output logic        resp_o
);

    logic [63:0] mem_q [logic [28:0]];  // sparse array keyed by beat address
    int          beat;
    int          delay;
    logic        finished;              // strobe still high after the last beat

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [63:0] load_burst(input logic [28:0] k);
        if (mem_q.exists(k)) return mem_q[k];
        return {fill_word({k, 3'b100}), fill_word({k, 3'b000})};
    endfunction

    initial begin
        resp_o   = 1'b0;
        rdata_o  = '0;
        beat     = 0;
        delay    = 0;
        finished = 1'b0;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            resp_o   <= 1'b0;
            beat     = 0;
            delay    = 0;
            finished = 1'b0;
        end else begin
            resp_o <= 1'b0;
            if (resp_o) begin  // adaptor takes the beat at this edge
                if (write_i) mem_q[address_i[31:3] + 29'(beat)] = wdata_i;
                beat = beat + 1;
                if (beat == 4) begin
                    finished = 1'b1;
                    beat     = 0;
                end
            end
            if (!(read_i || write_i)) finished = 1'b0;
            if ((read_i || write_i) && !finished) begin
                if (delay > 0) begin
                    delay = delay - 1;
                end else begin
                    resp_o  <= 1'b1;
                    rdata_o <= load_burst(address_i[31:3] + 29'(beat));
                    delay = $urandom_range(0, 3);  // gap before the next beat
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_mem_sys.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module tb_mem_sys;

    logic                   clk;
    logic                   reset_i;
    mem_types_pkg::word_t   imem_address_i;
    logic                   imem_read_i;
    mem_types_pkg::word_t   imem_rdata_o;
    logic                   imem_resp_o;
    mem_types_pkg::word_t   dmem_address_i;
    logic                   dmem_read_i;
    logic                   dmem_write_i;
    mem_types_pkg::wmask_t  dmem_wmask_i;
    mem_types_pkg::word_t   dmem_wdata_i;
    mem_types_pkg::word_t   dmem_rdata_o;
    logic                   dmem_resp_o;
    mem_types_pkg::word_t   bmem_address_o;
    logic                   bmem_read_o;
    logic                   bmem_write_o;
    mem_types_pkg::burst_t  bmem_rdata_i;
    mem_types_pkg::burst_t  bmem_wdata_o;
    logic                   bmem_resp_i;
    logic                   csr_wr_i;
    mem_types_pkg::word_t   csr_wdata_i;
    logic [`CSR_ADDR_W-1:0] csr_addr_i;
    mem_types_pkg::word_t   csr_rdata_o;

    // reference model of the CPU view of memory plus a tag mirror per cache
    mem_types_pkg::word_t      ref_mem [logic [29:0]];
    mem_types_pkg::tag_t       i_tag [2**`MEM_SETS_W];
    mem_types_pkg::tag_t       d_tag [2**`MEM_SETS_W];
    logic [2**`MEM_SETS_W-1:0] i_valid;
    logic [2**`MEM_SETS_W-1:0] d_valid;
    logic [2**`MEM_SETS_W-1:0] d_dirty;
    int exp_ihit, exp_imiss, exp_dhit, exp_dmiss, exp_wb;
    int wb_beats;
    int checks;
    int errors;

    mem_sys dut (
        .clk(clk), .reset_i(reset_i),
        .imem_address_i(imem_address_i), .imem_read_i(imem_read_i),
        .imem_rdata_o(imem_rdata_o), .imem_resp_o(imem_resp_o),
        .dmem_address_i(dmem_address_i), .dmem_read_i(dmem_read_i),
        .dmem_write_i(dmem_write_i), .dmem_wmask_i(dmem_wmask_i),
        .dmem_wdata_i(dmem_wdata_i), .dmem_rdata_o(dmem_rdata_o), .dmem_resp_o(dmem_resp_o),
        .bmem_address_o(bmem_address_o), .bmem_read_o(bmem_read_o),
        .bmem_write_o(bmem_write_o), .bmem_rdata_i(bmem_rdata_i),
        .bmem_wdata_o(bmem_wdata_o), .bmem_resp_i(bmem_resp_i),
        .csr_wr_i(csr_wr_i), .csr_wdata_i(csr_wdata_i),
        .csr_addr_i(csr_addr_i), .csr_rdata_o(csr_rdata_o)
    );

    burst_mem_model mem_model (
        .clk(clk), .reset_i(reset_i), .address_i(bmem_address_o),
        .read_i(bmem_read_o), .write_i(bmem_write_o), .wdata_i(bmem_wdata_o),
        .rdata_o(bmem_rdata_i), .resp_o(bmem_resp_i)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (bmem_write_o && bmem_resp_i) wb_beats++;  // one per written burst
    end

    // power-on contents as a function of the whole byte address
    function automatic mem_types_pkg::word_t init_word(input mem_types_pkg::word_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic mem_types_pkg::word_t ref_read(input mem_types_pkg::word_t addr);
        if (ref_mem.exists(addr[31:2])) return ref_mem[addr[31:2]];
        return init_word({addr[31:2], 2'b00});
    endfunction

    function automatic void ref_write(input mem_types_pkg::word_t addr,
                                      input mem_types_pkg::word_t data,
                                      input mem_types_pkg::wmask_t mask);
        mem_types_pkg::word_t w;
        w = ref_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        ref_mem[addr[31:2]] = w;
    endfunction

    function automatic logic predict_icache(input mem_types_pkg::word_t addr);
        mem_types_pkg::set_t s;
        mem_types_pkg::tag_t t;
        logic                hit;
        s   = addr[`MEM_OFFSET_W +: `MEM_SETS_W];
        t   = addr[`MEM_ADDR_W-1:`MEM_OFFSET_W+`MEM_SETS_W];
        hit = i_valid[s] && (i_tag[s] == t);
        if (hit) begin
            exp_ihit++;
        end else begin
            exp_imiss++;
            i_valid[s] = 1'b1;
            i_tag[s]   = t;
        end
        return hit;
    endfunction

    function automatic logic predict_dcache(input mem_types_pkg::word_t addr, input logic write);
        mem_types_pkg::set_t s;
        mem_types_pkg::tag_t t;
        logic                hit;
        s   = addr[`MEM_OFFSET_W +: `MEM_SETS_W];
        t   = addr[`MEM_ADDR_W-1:`MEM_OFFSET_W+`MEM_SETS_W];
        hit = d_valid[s] && (d_tag[s] == t);
        if (hit) begin
            exp_dhit++;
            d_dirty[s] = d_dirty[s] | write;
        end else begin
            exp_dmiss++;
            if (d_valid[s] && d_dirty[s]) exp_wb++;  // victim goes back first
            d_valid[s] = 1'b1;
            d_tag[s]   = t;
            d_dirty[s] = write;
        end
        return hit;
    endfunction

    task automatic check_word(input string what, input mem_types_pkg::word_t got,
                              input mem_types_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_hit_latency(input string what, input int n);
        checks++;
        if (n != 1) begin
            errors++;
            $display("[FAIL] %0t: %s hit answered after %0d cycles, expected 1", $time, what, n);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $finish;
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
            $display("test %s: passed", name);
        else
            $display("test %s: failed with %0d errors", name, errors - err_before);
    endtask

    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] a, output mem_types_pkg::word_t v);
        @(posedge clk);
        csr_addr_i <= a;
        @(negedge clk);
        v = csr_rdata_o;  // combinational read port
    endtask

    task automatic write_prio(input logic p);
        @(posedge clk);
        csr_wr_i    <= 1'b1;
        csr_wdata_i <= {31'b0, p};
        @(posedge clk);
        csr_wr_i    <= 1'b0;
    endtask

    task automatic ifetch(input mem_types_pkg::word_t addr);
        mem_types_pkg::word_t exp;
        logic                 hit;
        int                   n;
        hit = predict_icache(addr);
        exp = ref_read(addr);
        @(posedge clk);
        imem_address_i <= addr;
        imem_read_i    <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!imem_resp_o && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!imem_resp_o) begin
            abort_run($sformatf("imem fetch of %h got no response within 200 cycles", addr));
        end else begin
            check_word($sformatf("imem fetch %h", addr), imem_rdata_o, exp);
            if (hit) check_hit_latency("imem", n);
            @(posedge clk);
            imem_read_i <= 1'b0;
        end
    endtask

    task automatic dmem_access(input mem_types_pkg::word_t addr, input logic write,
                               input mem_types_pkg::wmask_t mask,
                               input mem_types_pkg::word_t data);
        mem_types_pkg::word_t exp;
        logic                 hit;
        int                   n;
        hit = predict_dcache(addr, write);
        if (write) ref_write(addr, data, mask);
        exp = ref_read(addr);
        @(posedge clk);
        dmem_address_i <= addr;
        dmem_read_i    <= ~write;
        dmem_write_i   <= write;
        dmem_wmask_i   <= mask;
        dmem_wdata_i   <= data;
        n = 0;
        @(negedge clk);
        while (!dmem_resp_o && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!dmem_resp_o) begin
            abort_run($sformatf("dmem access to %h got no response within 200 cycles", addr));
        end else begin
            if (!write) check_word($sformatf("dmem read %h", addr), dmem_rdata_o, exp);
            if (hit) check_hit_latency("dmem", n);
            @(posedge clk);
            dmem_read_i  <= 1'b0;
            dmem_write_i <= 1'b0;
        end
    endtask

    initial begin
        mem_types_pkg::word_t a;
        mem_types_pkg::word_t ia;
        mem_types_pkg::word_t da;
        mem_types_pkg::word_t v;
        int                   err0;
        void'($urandom(32'h4096));
        clk            = 1'b0;
        reset_i        = 1'b1;
        imem_address_i = '0;
        imem_read_i    = 1'b0;
        dmem_address_i = '0;
        dmem_read_i    = 1'b0;
        dmem_write_i   = 1'b0;
        dmem_wmask_i   = '0;
        dmem_wdata_i   = '0;
        csr_wr_i       = 1'b0;
        csr_wdata_i    = '0;
        csr_addr_i     = '0;
        i_valid = '0;
        d_valid = '0;
        d_dirty = '0;
        {exp_ihit, exp_imiss, exp_dhit, exp_dmiss, exp_wb} = '0;
        wb_beats = 0;
        checks   = 0;
        errors   = 0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        // quiet after reset with counters and priority bit clear
        err0 = errors;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            checks++;
            if (imem_resp_o || dmem_resp_o || bmem_read_o || bmem_write_o) begin
                errors++;
                $display("[FAIL] %0t: response or burst strobe high while idle", $time);
            end
        end
        for (int r = 0; r < 5; r++) begin
            read_csr(3'(r), v);
            check_word($sformatf("register %0d after reset", r), v, '0);
        end
        report_test("reset state", err0);

        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            a = 32'h0000_1000 | (($urandom % 1024) << 2);
            ifetch(a);
            ifetch(a);  // same word again must hit
        end
        report_test("instruction reads", err0);

        err0 = errors;
        for (int i = 0; i < 24; i++) begin
            a = 32'h0001_0000 | (($urandom % 256) << 2);
            dmem_access(a, 1'b1, 4'($urandom_range(1, 15)), $urandom);
            dmem_access(a, 1'b0, 4'h0, '0);
        end
        // three tags per set force dirty evictions that are read back from memory
        for (int s = 0; s < 8; s++) begin
            a = 32'h0001_4000 + 32'(s * 32) + (($urandom % 8) << 2);
            dmem_access(a, 1'b1, 4'hf, $urandom);
            dmem_access(a + 32'h100, 1'b1, 4'($urandom_range(1, 15)), $urandom);
            dmem_access(a + 32'h200, 1'b1, 4'($urandom_range(1, 15)), $urandom);
            dmem_access(a, 1'b0, 4'h0, '0);
            dmem_access(a + 32'h100, 1'b0, 4'h0, '0);
        end
        report_test("data writes and evictions", err0);

        err0 = errors;
        for (int p = 0; p < 2; p++) begin
            write_prio(1'(p));
            read_csr(3'd4, v);
            check_word("priority bit", v, mem_types_pkg::word_t'(p));
            for (int i = 0; i < 4; i++) begin
                ia = 32'h0000_2000 | (($urandom % 1024) << 2);
                da = 32'h0001_0000 | (($urandom % 1024) << 2);
                fork
                    ifetch(ia);
                    dmem_access(da, 1'b0, 4'h0, '0);
                join
            end
        end
        report_test("concurrent misses", err0);

        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            a = 32'h0002_0000 + 32'(i * 64) + (($urandom % 8) << 2);
            dmem_access(a, 1'b1, 4'($urandom_range(1, 15)), $urandom);
            dmem_access(a ^ 32'h0000_0800, 1'b0, 4'h0, '0);  // same set so the line is pushed out
            ifetch(a);
        end
        report_test("fetch after store", err0);

        err0 = errors;
        read_csr(3'd0, v);
        check_word("icache hit count", v, mem_types_pkg::word_t'(exp_ihit));
        read_csr(3'd1, v);
        check_word("icache miss count", v, mem_types_pkg::word_t'(exp_imiss));
        read_csr(3'd2, v);
        check_word("dcache hit count", v, mem_types_pkg::word_t'(exp_dhit));
        read_csr(3'd3, v);
        check_word("dcache miss count", v, mem_types_pkg::word_t'(exp_dmiss));
        checks++;
        if (wb_beats != 4 * exp_wb) begin
            errors++;
            $display("[FAIL] %0t: saw %0d write-back beats, expected %0d",
                     $time, wb_beats, 4 * exp_wb);
        end
        report_test("event counters", err0);

        $display("checks %0d, errors %0d, icache %0d hits %0d misses, dcache %0d hits %0d misses",
                 checks, errors, exp_ihit, exp_imiss, exp_dhit, exp_dmiss);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/mem_types_pkg.sv
design/mem_fsm_pkg.sv
design/cache.sv
design/cache_arbiter.sv
design/cacheline_adaptor.sv
design/mem_sys_csr.sv
design/mem_sys.sv
verif/burst_mem_model.sv
verif/tb_mem_sys.sv

// File: Makefile
# Verilator build and run for the memory system testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_sys
LINT_TOP  ?= mem_sys
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
